//--- source/rv_pkg.sv
// rv32i pipeline shared types
// enums for the control fields, the instruction word union and the
// structs that travel between control, datapath and the memories
package rv_pkg;

   typedef logic [31:0] xlen_t;

   typedef enum logic [1:0] {PC_4, PC_BRJMP, PC_JALR} pc_sel_e;
   typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
   typedef enum logic [2:0] {
      OP2_RS2, OP2_ITYPE, OP2_STYPE, OP2_SBTYPE, OP2_UTYPE, OP2_UJTYPE
   } op2_sel_e;
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_COPY2
   } alu_fun_e;
   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
   typedef enum logic [2:0] {BR_N, BR_EQ, BR_NE, BR_LT, BR_GE, BR_J, BR_JR} br_type_e;

   // one instruction word seen through each base format
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm4_0;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm12;
         logic [5:0] imm10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm4_1;
         logic       imm11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm20;
         logic [9:0] imm10_1;
         logic       imm11;
         logic [7:0] imm19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
   } rv_inst_u;

   localparam rv_inst_u BUBBLE = 32'h0000_0013; // addi x0,x0,0

   typedef struct packed {
      logic     dec_stall;
      logic     if_kill;
      logic     dec_kill;
      pc_sel_e  pc_sel;
      op1_sel_e op1_sel;  // decode stage fields from here on
      op2_sel_e op2_sel;
      alu_fun_e alu_fun;
      wb_sel_e  wb_sel;
      logic     rf_wen;
      logic     mem_val;
      logic     mem_wr;
   } ctl_to_dat_t;

   typedef struct packed {
      rv_inst_u   dec_inst;
      logic [4:0] exe_rd;
      logic       exe_wen;
      logic       exe_is_load;
      logic       br_eq;   // rs1 == rs2 in execute
      logic       br_lt;   // signed
      logic       br_ltu;
   } dat_to_ctl_t;

   typedef struct packed {
      logic  valid;
      logic  write;
      xlen_t addr;
      xlen_t wdata;
   } mem_req_t;

   typedef struct packed {
      xlen_t rdata;
   } mem_rsp_t;

endpackage

//--- source/rv_alu.sv
// execute stage ALU
// purely combinational, eight functions incl. signed/unsigned compare
`timescale 1ns/1ps

module rv_alu
   import rv_pkg::*;
(
   input  xlen_t    op1,
   input  xlen_t    op2,
   input  alu_fun_e fun,
   output xlen_t    result
);

   logic lt_s;
   logic lt_u;

   assign lt_s = $signed(op1) < $signed(op2);
   assign lt_u = op1 < op2;

   always_comb begin
      case (fun)
         ALU_ADD:   result = op1 + op2;
         ALU_SUB:   result = op1 - op2;
         ALU_AND:   result = op1 & op2;
         ALU_OR:    result = op1 | op2;
         ALU_XOR:   result = op1 ^ op2;
         ALU_SLT:   result = {31'd0, lt_s};
         ALU_SLTU:  result = {31'd0, lt_u};
         ALU_COPY2: result = op2;  // lui path
         default:   result = op1 + op2;
      endcase
   end

endmodule

//--- source/rv_regfile.sv
// integer register file, 32 x 32 bit
// two combinational read ports, one write port at the clock edge
`timescale 1ns/1ps

module rv_regfile
   import rv_pkg::*;
(
   input  logic       clk,
   input  logic [4:0] rs1_addr,
   input  logic [4:0] rs2_addr,
   output xlen_t      rs1_data,
   output xlen_t      rs2_data,
   input  logic       we,
   input  logic [4:0] waddr,
   input  xlen_t      wdata
);

   xlen_t regs [32];

   // x0 is hardwired, whatever the array holds
   assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

   // same cycle read of waddr sees old value
   always_ff @(posedge clk) begin
      if (we && waddr != 5'd0) begin
         regs[waddr] <= wdata;
      end
   end

endmodule

//--- source/rv_control.sv
// pipeline control unit
// decodes the instruction in decode, resolves branches in execute
// and produces stall, kill and next-pc select
`timescale 1ns/1ps

module rv_control
   import rv_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  dat_to_ctl_t dat,
   output ctl_to_dat_t ctl
);

   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   rv_inst_u inst;
   br_type_e dec_br_type;
   br_type_e exe_br_type;  // branch type of the instruction in execute
   logic     rs1_used;
   logic     rs2_used;
   logic     load_use;
   logic     exe_take;

   assign inst = dat.dec_inst;

   always_comb begin
      ctl         = '0;  // defaults give a bubble
      ctl.op1_sel = OP1_RS1;
      ctl.op2_sel = OP2_ITYPE;
      ctl.alu_fun = ALU_ADD;
      ctl.wb_sel  = WB_ALU;
      dec_br_type = BR_N;
      rs1_used    = 1'b0;
      rs2_used    = 1'b0;

      case (inst.r.opcode)
         OPC_LUI: begin
            ctl.op1_sel = OP1_ZERO;
            ctl.op2_sel = OP2_UTYPE;
            ctl.alu_fun = ALU_COPY2;
            ctl.rf_wen  = 1'b1;
         end
         OPC_AUIPC: begin
            ctl.op1_sel = OP1_PC;
            ctl.op2_sel = OP2_UTYPE;
            ctl.rf_wen  = 1'b1;
         end
         OPC_JAL: begin
            ctl.op1_sel = OP1_PC;
            ctl.op2_sel = OP2_UJTYPE;
            ctl.wb_sel  = WB_PC4;
            ctl.rf_wen  = 1'b1;
            dec_br_type = BR_J;
         end
         OPC_JALR: begin
            if (inst.i.funct3 == 3'b000) begin
               ctl.wb_sel  = WB_PC4;
               ctl.rf_wen  = 1'b1;
               dec_br_type = BR_JR;
               rs1_used    = 1'b1;
            end
         end
         OPC_BRANCH: begin
            ctl.op2_sel = OP2_SBTYPE;  // target = pc + imm
            rs1_used    = 1'b1;
            rs2_used    = 1'b1;
            case (inst.b.funct3)
               3'b000:  dec_br_type = BR_EQ;
               3'b001:  dec_br_type = BR_NE;
               3'b100:  dec_br_type = BR_LT;
               3'b101:  dec_br_type = BR_GE;
               default: begin
                  rs1_used = 1'b0;
                  rs2_used = 1'b0;
               end
            endcase
         end
         OPC_LOAD: begin
            if (inst.i.funct3 == 3'b010) begin  // lw only
               ctl.wb_sel  = WB_MEM;
               ctl.rf_wen  = 1'b1;
               ctl.mem_val = 1'b1;
               rs1_used    = 1'b1;
            end
         end
         OPC_STORE: begin
            if (inst.s.funct3 == 3'b010) begin  // sw only
               ctl.op2_sel = OP2_STYPE;
               ctl.mem_val = 1'b1;
               ctl.mem_wr  = 1'b1;
               rs1_used    = 1'b1;
               rs2_used    = 1'b1;
            end
         end
         OPC_OPIMM: begin
            rs1_used   = 1'b1;
            ctl.rf_wen = 1'b1;
            case (inst.i.funct3)
               3'b000:  ctl.alu_fun = ALU_ADD;
               3'b111:  ctl.alu_fun = ALU_AND;
               3'b110:  ctl.alu_fun = ALU_OR;
               3'b100:  ctl.alu_fun = ALU_XOR;
               default: begin
                  ctl.rf_wen = 1'b0;
                  rs1_used   = 1'b0;
               end
            endcase
         end
         OPC_OP: begin
            ctl.op2_sel = OP2_RS2;
            rs1_used    = 1'b1;
            rs2_used    = 1'b1;
            ctl.rf_wen  = 1'b1;
            case ({inst.r.funct7, inst.r.funct3})
               10'b0000000_000: ctl.alu_fun = ALU_ADD;
               10'b0100000_000: ctl.alu_fun = ALU_SUB;
               10'b0000000_111: ctl.alu_fun = ALU_AND;
               10'b0000000_110: ctl.alu_fun = ALU_OR;
               10'b0000000_100: ctl.alu_fun = ALU_XOR;
               10'b0000000_010: ctl.alu_fun = ALU_SLT;
               10'b0000000_011: ctl.alu_fun = ALU_SLTU;
               default: begin
                  ctl.rf_wen = 1'b0;
                  rs1_used   = 1'b0;
                  rs2_used   = 1'b0;
               end
            endcase
         end
         default: ;  // unsupported, runs as a bubble
      endcase

      // branch resolution in execute
      case (exe_br_type)
         BR_EQ:   exe_take = dat.br_eq;
         BR_NE:   exe_take = !dat.br_eq;
         BR_LT:   exe_take = dat.br_lt;
         BR_GE:   exe_take = !dat.br_lt;
         BR_J,
         BR_JR:   exe_take = 1'b1;
         default: exe_take = 1'b0;
      endcase

      if (!exe_take) begin
         ctl.pc_sel = PC_4;
      end else if (exe_br_type == BR_JR) begin
         ctl.pc_sel = PC_JALR;
      end else begin
         ctl.pc_sel = PC_BRJMP;
      end
      ctl.if_kill  = exe_take;
      ctl.dec_kill = exe_take;

      // a load in execute cannot also be a taken branch
      load_use = dat.exe_wen && dat.exe_is_load && dat.exe_rd != 5'd0 &&
                 ((rs1_used && inst.r.rs1 == dat.exe_rd) ||
                  (rs2_used && inst.r.rs2 == dat.exe_rd));
      ctl.dec_stall = load_use;
   end

   // follows the datapath execute register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exe_br_type <= BR_N;
      end else if (ctl.dec_kill || ctl.dec_stall) begin
         exe_br_type <= BR_N;
      end else begin
         exe_br_type <= dec_br_type;
      end
   end

endmodule

//--- source/rv_datapath.sv
// five stage rv32i datapath
// fetch, decode, execute, memory and writeback registers with
// bypassing into decode, immediate generation and the memory ports
`timescale 1ns/1ps

module rv_datapath
   import rv_pkg::*;
#(
   parameter xlen_t reset_vector = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        arst_n,
   input  ctl_to_dat_t ctl,
   output dat_to_ctl_t dat,
   output mem_req_t    imem_req,
   input  mem_rsp_t    imem_rsp,
   output mem_req_t    dmem_req,
   input  mem_rsp_t    dmem_rsp
);

   typedef struct packed {
      xlen_t pc;
   } if_state_t;

   typedef struct packed {
      xlen_t    pc;
      rv_inst_u inst;
   } id_state_t;

   typedef struct packed {
      xlen_t      pc;
      xlen_t      op1;
      xlen_t      op2;
      xlen_t      rs2_data;  // store data and branch compare
      logic [4:0] rd;
      alu_fun_e   alu_fun;
      wb_sel_e    wb_sel;
      logic       rf_wen;
      logic       mem_val;
      logic       mem_wr;
   } ex_state_t;

   typedef struct packed {
      xlen_t      alu_out;  // link value already folded in
      xlen_t      rs2_data;
      logic [4:0] rd;
      wb_sel_e    wb_sel;
      logic       rf_wen;
      logic       mem_val;
      logic       mem_wr;
   } mem_state_t;

   typedef struct packed {
      xlen_t      data;
      logic [4:0] rd;
      logic       rf_wen;
   } wb_state_t;

   if_state_t  fs;
   id_state_t  ds;
   ex_state_t  es;
   mem_state_t ms;
   wb_state_t  ws;

   xlen_t pc_next;
   xlen_t rf_rs1;
   xlen_t rf_rs2;
   xlen_t rs1_fwd;
   xlen_t rs2_fwd;
   xlen_t dec_op1;
   xlen_t dec_op2;
   xlen_t alu_result;
   xlen_t exe_wb_data;
   xlen_t mem_wb_data;
   xlen_t brjmp_target;
   xlen_t jalr_target;

   // youngest producer wins, x0 never forwarded
   function automatic xlen_t bypass(input logic [4:0] addr, input xlen_t rf_val);
      if (addr == 5'd0) begin
         return rf_val;
      end
      if (es.rf_wen && es.rd == addr) begin
         return exe_wb_data;
      end
      if (ms.rf_wen && ms.rd == addr) begin
         return mem_wb_data;
      end
      if (ws.rf_wen && ws.rd == addr) begin
         return ws.data;
      end
      return rf_val;
   endfunction

   // fetch
   assign brjmp_target = es.pc + es.op2;
   assign jalr_target  = {alu_result[31:1], 1'b0};

   always_comb begin
      case (ctl.pc_sel)
         PC_BRJMP: pc_next = brjmp_target;
         PC_JALR:  pc_next = jalr_target;
         default:  pc_next = ctl.dec_stall ? fs.pc : fs.pc + 32'd4;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fs.pc <= reset_vector;
      end else begin
         fs.pc <= pc_next;
      end
   end

   assign imem_req.valid = 1'b1;
   assign imem_req.write = 1'b0;
   assign imem_req.addr  = fs.pc;
   assign imem_req.wdata = '0;

   // decode
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ds.pc   <= reset_vector;
         ds.inst <= BUBBLE;
      end else if (ctl.if_kill) begin
         ds.inst <= BUBBLE;
      end else if (!ctl.dec_stall) begin
         ds.pc   <= fs.pc;
         ds.inst <= imem_rsp.rdata;
      end
   end

   rv_regfile i_regfile (
      .clk      (clk),
      .rs1_addr (ds.inst.r.rs1),
      .rs2_addr (ds.inst.r.rs2),
      .rs1_data (rf_rs1),
      .rs2_data (rf_rs2),
      .we       (ws.rf_wen),
      .waddr    (ws.rd),
      .wdata    (ws.data)
   );

   always_comb begin
      rs1_fwd = bypass(ds.inst.r.rs1, rf_rs1);
      rs2_fwd = bypass(ds.inst.r.rs2, rf_rs2);
   end

   always_comb begin
      case (ctl.op1_sel)
         OP1_RS1: dec_op1 = rs1_fwd;
         OP1_PC:  dec_op1 = ds.pc;
         default: dec_op1 = '0;
      endcase

      // sign-extended immediates straight from the union views
      case (ctl.op2_sel)
         OP2_RS2:    dec_op2 = rs2_fwd;
         OP2_ITYPE:  dec_op2 = {{20{ds.inst.i.imm11_0[11]}}, ds.inst.i.imm11_0};
         OP2_STYPE:  dec_op2 = {{20{ds.inst.s.imm11_5[6]}}, ds.inst.s.imm11_5,
                                ds.inst.s.imm4_0};
         OP2_SBTYPE: dec_op2 = {{20{ds.inst.b.imm12}}, ds.inst.b.imm11,
                                ds.inst.b.imm10_5, ds.inst.b.imm4_1, 1'b0};
         OP2_UTYPE:  dec_op2 = {ds.inst.u.imm31_12, 12'd0};
         OP2_UJTYPE: dec_op2 = {{12{ds.inst.j.imm20}}, ds.inst.j.imm19_12,
                                ds.inst.j.imm11, ds.inst.j.imm10_1, 1'b0};
         default:    dec_op2 = '0;
      endcase
   end

   // execute
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         es <= '0;
      end else if (ctl.dec_kill || ctl.dec_stall) begin
         es.rd      <= 5'd0;  // bubble
         es.wb_sel  <= WB_ALU;
         es.rf_wen  <= 1'b0;
         es.mem_val <= 1'b0;
         es.mem_wr  <= 1'b0;
      end else begin
         es.pc       <= ds.pc;
         es.op1      <= dec_op1;
         es.op2      <= dec_op2;
         es.rs2_data <= rs2_fwd;
         es.rd       <= ds.inst.r.rd;
         es.alu_fun  <= ctl.alu_fun;
         es.wb_sel   <= ctl.wb_sel;
         es.rf_wen   <= ctl.rf_wen;
         es.mem_val  <= ctl.mem_val;
         es.mem_wr   <= ctl.mem_wr;
      end
   end

   rv_alu i_alu (
      .op1    (es.op1),
      .op2    (es.op2),
      .fun    (es.alu_fun),
      .result (alu_result)
   );

   assign exe_wb_data = (es.wb_sel == WB_PC4) ? es.pc + 32'd4 : alu_result;

   // memory
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ms <= '0;
      end else begin
         ms.alu_out  <= exe_wb_data;
         ms.rs2_data <= es.rs2_data;
         ms.rd       <= es.rd;
         ms.wb_sel   <= es.wb_sel;
         ms.rf_wen   <= es.rf_wen;
         ms.mem_val  <= es.mem_val;
         ms.mem_wr   <= es.mem_wr;
      end
   end

   assign dmem_req.valid = ms.mem_val;
   assign dmem_req.write = ms.mem_wr;
   assign dmem_req.addr  = ms.alu_out;
   assign dmem_req.wdata = ms.rs2_data;

   assign mem_wb_data = (ms.wb_sel == WB_MEM) ? dmem_rsp.rdata : ms.alu_out;

   // writeback
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ws <= '0;
      end else begin
         ws.data   <= mem_wb_data;
         ws.rd     <= ms.rd;
         ws.rf_wen <= ms.rf_wen;
      end
   end

   // to control
   assign dat.dec_inst    = ds.inst;
   assign dat.exe_rd      = es.rd;
   assign dat.exe_wen     = es.rf_wen;
   assign dat.exe_is_load = (es.wb_sel == WB_MEM);
   assign dat.br_eq       = (es.op1 == es.rs2_data);
   assign dat.br_lt       = ($signed(es.op1) < $signed(es.rs2_data));
   assign dat.br_ltu      = (es.op1 < es.rs2_data);

endmodule

//--- source/rv_core.sv
// rv32i five stage core top level
// control unit and datapath joined, memory ports brought out
`timescale 1ns/1ps

module rv_core
   import rv_pkg::*;
#(
   parameter xlen_t reset_vector = 32'h0000_0000
) (
   input  logic     clk,
   input  logic     arst_n,
   output mem_req_t imem_req,
   input  mem_rsp_t imem_rsp,
   output mem_req_t dmem_req,
   input  mem_rsp_t dmem_rsp
);

   ctl_to_dat_t ctl;
   dat_to_ctl_t dat;

   rv_control i_control (
      .clk    (clk),
      .arst_n (arst_n),
      .dat    (dat),
      .ctl    (ctl)
   );

   rv_datapath #(
      .reset_vector (reset_vector)
   ) i_datapath (
      .clk      (clk),
      .arst_n   (arst_n),
      .ctl      (ctl),
      .dat      (dat),
      .imem_req (imem_req),
      .imem_rsp (imem_rsp),
      .dmem_req (dmem_req),
      .dmem_rsp (dmem_rsp)
   );

endmodule

//--- verif/tb_mem.sv
// testbench memory model for the rv32i core
// instruction and data arrays that answer in the same cycle,
// every store is logged as {addr, data}
`timescale 1ns/1ps

module tb_mem
   import rv_pkg::*;
(
   input  logic     clk,
   input  mem_req_t imem_req,
   output mem_rsp_t imem_rsp,
   input  mem_req_t dmem_req,
   output mem_rsp_t dmem_rsp
);

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [63:0] store_log [$];

   // word addressed, upper address bits ignored
   // only a valid request gets data back
   assign imem_rsp.rdata = imem_req.valid ? imem[imem_req.addr[9:2]] : '0;
   assign dmem_rsp.rdata = dmem_req.valid ? dmem[dmem_req.addr[9:2]] : '0;

   initial begin
      for (int i = 0; i < 256; i++) begin
         dmem[i[7:0]] = 32'hd00d_0000 | (i << 2);  // byte address in the low bits
      end
   end

   // write lands at the edge that ends the request cycle
   always @(posedge clk) begin
      if (dmem_req.valid && dmem_req.write) begin
         dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
         store_log.push_back({dmem_req.addr, dmem_req.wdata});
      end
   end

   task automatic write_inst(input logic [7:0] idx, input logic [31:0] word);
      imem[idx] = word;
   endtask

   task automatic fill_program(input logic [31:0] word);
      for (int i = 0; i < 256; i++) begin
         imem[i[7:0]] = word;
      end
   endtask

   task automatic clear_stores();
      store_log.delete();
   endtask

   function automatic int store_count();
      return store_log.size();
   endfunction

   function automatic logic [63:0] store_at(input int k);
      return store_log[k];
   endfunction

endmodule

//--- verif/tb_core.sv
// testbench for the rv32i five stage core
// assembles small programs into the memory model, runs them
// and compares the logged stores with the rv32i results
`timescale 1ns/1ps

module tb_core
   import rv_pkg::*;
();

   localparam int TIMEOUT = 200;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [31:0] SELF_JUMP = 32'h0000_006f;  // jal x0,0

   logic     clk;
   logic     arst_n;
   mem_req_t imem_req;
   mem_rsp_t imem_rsp;
   mem_req_t dmem_req;
   mem_rsp_t dmem_rsp;

   logic [31:0] rng;
   int          prog_len;
   int          n_tests;
   int          n_checks;
   int          n_errors;
   int          test_checks;
   int          test_errors;
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   rv_core #(
      .reset_vector (32'h0000_0000)
   ) i_dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .imem_req (imem_req),
      .imem_rsp (imem_rsp),
      .dmem_req (dmem_req),
      .dmem_rsp (dmem_rsp)
   );

   tb_mem i_mem (
      .clk      (clk),
      .imem_req (imem_req),
      .imem_rsp (imem_rsp),
      .dmem_req (dmem_req),
      .dmem_rsp (dmem_rsp)
   );

   // instruction encoders, fields sliced from plain ints
   function automatic logic [31:0] rtype(int f7, int f3, int rd, int rs1, int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
   endfunction

   function automatic logic [31:0] itype(int imm, int f3, int rd, int rs1, logic [6:0] opc);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
   endfunction

   function automatic logic [31:0] stype(int imm, int rs2, int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
   endfunction

   function automatic logic [31:0] btype(int imm, int f3, int rs1, int rs2);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] utype(int imm20, int rd, logic [6:0] opc);
      return {imm20[19:0], rd[4:0], opc};
   endfunction

   function automatic logic [31:0] jtype(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic branch_taken(int f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         0:       return a == b;
         1:       return a != b;
         4:       return $signed(a) < $signed(b);
         default: return $signed(a) >= $signed(b);
      endcase
   endfunction

   task automatic draw_random(output logic [31:0] v);
      rng = xorshift(rng);
      v = rng;
   endtask

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic emit(input logic [31:0] word);
      i_mem.write_inst(prog_len[7:0], word);
      prog_len++;
   endtask

   // lui + addi, upper part rounded for the sign of the low 12 bits
   task automatic load_const(input int rd, input logic [31:0] value);
      logic [31:0] hi;
      hi = value + 32'h800;
      emit(utype(hi >> 12, rd, OP_LUI));
      emit(itype(value & 32'hfff, 0, rd, rd, OP_IMM));
   endtask

   task automatic expect_store(input int addr, input logic [31:0] data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic begin_test();
      @(posedge clk);
      arst_n <= 1'b0;
      i_mem.fill_program(SELF_JUMP);  // idle loop everywhere
      i_mem.clear_stores();
      exp_addr.delete();
      exp_data.delete();
      prog_len    = 0;
      test_checks = n_checks;
      test_errors = n_errors;
   endtask

   task automatic run_and_check(input string name);
      int          n;
      int          cyc;
      int          seen;
      logic [63:0] entry;
      n = exp_addr.size();
      repeat (4) @(posedge clk);
      @(negedge clk);
      compare(i_mem.store_count(), 0, "stores during reset");
      @(posedge clk);
      arst_n <= 1'b1;
      cyc = 0;
      while (i_mem.store_count() < n && cyc < TIMEOUT) begin
         @(negedge clk);
         cyc++;
      end
      if (i_mem.store_count() < n) begin
         n_errors++;
         $display("Timeout in %s: only %0d of %0d stores after %0d cycles",
                  name, i_mem.store_count(), n, TIMEOUT);
      end
      repeat (10) @(negedge clk);  // core sits in the idle loop by now
      seen = i_mem.store_count();
      compare(seen, n, $sformatf("%s store count", name));
      for (int k = 0; k < n && k < seen; k++) begin
         entry = i_mem.store_at(k);
         compare(entry[63:32], exp_addr[k], $sformatf("%s store %0d addr", name, k));
         compare(entry[31:0], exp_data[k], $sformatf("%s store %0d data", name, k));
      end
      n_tests++;
      $display("%s: %0d checks, %0d errors", name, n_checks - test_checks,
               n_errors - test_errors);
   endtask

   // dependent chain, operands reach decode from all three stages
   task automatic test_alu(input int run);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] s;
      logic [31:0] d;
      logic [31:0] n;
      logic [31:0] o;
      logic [31:0] x;
      draw_random(a);
      draw_random(b);
      begin_test();
      load_const(1, a);
      load_const(2, b);
      emit(rtype(0, 0, 3, 1, 2));   // add  x3,x1,x2
      emit(stype(0, 3, 0));
      emit(rtype(32, 0, 4, 3, 1));  // sub  x4,x3,x1
      emit(stype(4, 4, 0));
      emit(rtype(0, 7, 5, 4, 2));   // and  x5,x4,x2
      emit(rtype(0, 6, 6, 5, 3));   // or   x6,x5,x3
      emit(stype(8, 5, 0));
      emit(stype(12, 6, 0));
      emit(rtype(0, 4, 7, 6, 1));   // xor  x7,x6,x1
      emit(rtype(0, 2, 8, 7, 2));   // slt  x8,x7,x2
      emit(rtype(0, 3, 9, 7, 2));   // sltu x9,x7,x2
      emit(stype(16, 7, 0));
      emit(stype(20, 8, 0));
      emit(stype(24, 9, 0));
      s = a + b;
      d = s - a;
      n = d & b;
      o = n | s;
      x = o ^ a;
      expect_store(0, s);
      expect_store(4, d);
      expect_store(8, n);
      expect_store(12, o);
      expect_store(16, x);
      expect_store(20, {31'd0, $signed(x) < $signed(b)});
      expect_store(24, {31'd0, x < b});
      run_and_check($sformatf("alu %0d", run));
   endtask

   task automatic test_load_use();
      logic [31:0] a;
      logic [31:0] b;
      draw_random(a);
      draw_random(b);
      begin_test();
      load_const(1, a);
      load_const(2, b);
      emit(stype(32, 1, 0));                // sw  x1,32(x0)
      emit(itype(32, 2, 3, 0, OP_LOAD));    // lw  x3,32(x0)
      emit(rtype(0, 0, 4, 3, 2));           // add right behind the load
      emit(stype(36, 4, 0));
      emit(itype(32, 2, 5, 0, OP_LOAD));
      emit(stype(40, 5, 0));                // load data used as store data
      expect_store(32, a);
      expect_store(36, a + b);
      expect_store(40, a);
      run_and_check("load use");
   endtask

   task automatic test_branch(input int f3, input logic want);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] tmp;
      logic        taken;
      string       kind;
      draw_random(a);
      draw_random(b);
      if (b == a) begin
         b = a + 32'd1;
      end
      if (f3 < 4) begin
         if ((f3 == 0) == want) begin
            b = a;
         end
      end else if (($signed(a) < $signed(b)) != ((f3 == 4) == want)) begin
         tmp = a;
         a   = b;
         b   = tmp;
      end
      taken = branch_taken(f3, a, b);
      case (f3)
         0:       kind = "beq";
         1:       kind = "bne";
         4:       kind = "blt";
         default: kind = "bge";
      endcase
      begin_test();
      load_const(1, a);
      load_const(2, b);
      emit(btype(12, f3, 1, 2));  // to the target three words on
      emit(stype(0, 1, 0));       // fall through path
      emit(jtype(8, 0));          // step over the target
      emit(stype(4, 2, 0));       // target
      emit(stype(8, 1, 0));
      if (taken) begin
         expect_store(4, b);
      end else begin
         expect_store(0, a);
      end
      expect_store(8, a);
      run_and_check($sformatf("%s %s", kind, taken ? "taken" : "not taken"));
   endtask

   task automatic test_jumps();
      int jal_pc;
      int jalr_pc;
      jal_pc  = 8;
      jalr_pc = 28;
      begin_test();
      emit(itype(5, 0, 1, 0, OP_IMM));
      emit(itype(7, 0, 2, 0, OP_IMM));
      emit(jtype(12, 5));                  // jal x5, word 5
      emit(stype(64, 1, 0));               // skipped
      emit(stype(68, 2, 0));               // skipped
      emit(stype(0, 5, 0));
      emit(itype(47, 0, 6, 0, OP_IMM));
      emit(itype(1, 0, 7, 6, OP_JALR));    // 47 + 1, lsb already clear
      for (int k = 0; k < 4; k++) begin
         emit(stype(72 + 4 * k, 1, 0));    // skipped
      end
      emit(stype(4, 7, 0));                // word 12, jalr target
      emit(stype(8, 5, 0));
      expect_store(0, jal_pc + 4);
      expect_store(4, jalr_pc + 4);
      expect_store(8, jal_pc + 4);
      run_and_check("jumps");
   endtask

   task automatic test_zero();
      begin_test();
      emit(itype('h55, 0, 0, 0, OP_IMM));  // addi x0,x0,0x55
      emit(utype('habcde, 0, OP_LUI));     // lui x0
      emit(stype(0, 0, 0));
      emit(itype('h123, 0, 1, 0, OP_IMM));
      emit(stype(4, 1, 0));
      emit(stype(8, 0, 0));
      expect_store(0, 32'd0);
      expect_store(4, 32'h123);
      expect_store(8, 32'd0);
      run_and_check("x0 and reset");
   endtask

   initial begin
      arst_n   = 1'b0;
      rng      = 32'h2443;
      prog_len = 0;
      n_tests  = 0;
      n_checks = 0;
      n_errors = 0;
      i_mem.fill_program(SELF_JUMP);
      for (int r = 0; r < 3; r++) begin
         test_alu(r);
      end
      test_load_use();
      for (int w = 0; w < 2; w++) begin
         test_branch(0, w[0]);
         test_branch(1, w[0]);
         test_branch(4, w[0]);
         test_branch(5, w[0]);
      end
      test_jumps();
      test_zero();
      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- sim.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_control.sv
source/rv_datapath.sv
source/rv_core.sv
verif/tb_mem.sv
verif/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_core -f sim.f
out=$(./obj_dir/Vtb_core)
echo "$out"
if grep -qx "NO ERRORS" <<< "$out"; then
   exit 0
fi
exit 1
